//--- Bender.yml
package:
  name: rv_core

sources:
  - rv_core_pkg.sv
  - rv_pipe_if.sv
  - rv_regfile.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_result.sv
  - rv_core_top.sv
  - target: simulation
    files:
      - tb_rv_core.sv

//--- rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

	typedef logic [31:0] xlen_t;    // Data word or address
	typedef logic [4:0]  reg_idx_t; // Register index
	typedef logic [6:0]  opcode_t;  // Major opcode
	typedef logic [2:0]  funct3_t;

	localparam int NUM_REGS = 32;

	// ------------------------------
	// Major opcodes
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;

	// ------------------------------
	// funct3 values that steer the ALU op
	localparam funct3_t F3_SR   = 3'b101; // SRL/SRA, funct7 bit 5 picks
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	// Arithmetic ops are {funct7[5], funct3}, compares fill the gaps
	typedef enum logic [3:0] {
		ADD  = 4'b0000,
		SLL  = 4'b0001,
		SLT  = 4'b0010,
		SLTU = 4'b0011,
		XOR  = 4'b0100,
		SRL  = 4'b0101,
		OR   = 4'b0110,
		AND  = 4'b0111,
		SUB  = 4'b1000,
		EQ   = 4'b1001,
		NE   = 4'b1010,
		LT   = 4'b1011,
		GE   = 4'b1100,
		SRA  = 4'b1101,
		LTU  = 4'b1110,
		GEU  = 4'b1111
	} alu_op_e;

endpackage

`default_nettype wire

//--- rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_core_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  xlen_t    in_inst,
	input  xlen_t    in_pc,
	output logic     retire_valid,
	input  logic     retire_ready,
	output xlen_t    retire_pc,
	output reg_idx_t retire_rd,
	output logic     retire_we,
	output xlen_t    retire_data,
	output logic     retire_taken,
	output xlen_t    retire_target,
	output logic     retire_illegal
);

	reg_idx_t rs1;
	reg_idx_t rs2;
	xlen_t    rdata1;
	xlen_t    rdata2;
	logic     ex_valid;
	logic     ex_ready;
	xlen_t    ex_pc;
	reg_idx_t ex_rd;
	logic     ex_we;
	xlen_t    ex_data;
	logic     ex_taken;
	xlen_t    ex_target;
	logic     ex_illegal;
	logic     rf_we;
	reg_idx_t rf_waddr;
	xlen_t    rf_wdata;

	rv_stage_if stage_bus ();
	rv_fwd_if   fwd_ex_bus ();
	rv_fwd_if   fwd_rs_bus ();

	assign in_ready = stage_bus.ready;

	rv_decode i_rv_decode (
		.inst     (in_inst),
		.pc       (in_pc),
		.in_valid (in_valid),
		.rs1      (rs1),
		.rs2      (rs2),
		.rdata1   (rdata1),
		.rdata2   (rdata2),
		.fwd_ex   (fwd_ex_bus.sink),
		.fwd_rs   (fwd_rs_bus.sink),
		.stage    (stage_bus.decode)
	);

	rv_execute i_rv_execute (
		.clk        (clk),
		.arst_n     (arst_n),
		.stage      (stage_bus.execute),
		.fwd        (fwd_ex_bus.source),
		.ex_valid   (ex_valid),
		.ex_ready   (ex_ready),
		.ex_pc      (ex_pc),
		.ex_rd      (ex_rd),
		.ex_we      (ex_we),
		.ex_data    (ex_data),
		.ex_taken   (ex_taken),
		.ex_target  (ex_target),
		.ex_illegal (ex_illegal)
	);

	rv_result i_rv_result (
		.clk            (clk),
		.arst_n         (arst_n),
		.ex_valid       (ex_valid),
		.ex_ready       (ex_ready),
		.ex_pc          (ex_pc),
		.ex_rd          (ex_rd),
		.ex_we          (ex_we),
		.ex_data        (ex_data),
		.ex_taken       (ex_taken),
		.ex_target      (ex_target),
		.ex_illegal     (ex_illegal),
		.fwd            (fwd_rs_bus.source),
		.rf_we          (rf_we),
		.rf_waddr       (rf_waddr),
		.rf_wdata       (rf_wdata),
		.retire_valid   (retire_valid),
		.retire_ready   (retire_ready),
		.retire_pc      (retire_pc),
		.retire_rd      (retire_rd),
		.retire_we      (retire_we),
		.retire_data    (retire_data),
		.retire_taken   (retire_taken),
		.retire_target  (retire_target),
		.retire_illegal (retire_illegal)
	);

	rv_regfile i_rv_regfile (
		.clk    (clk),
		.arst_n (arst_n),
		.rs1    (rs1),
		.rs2    (rs2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.we     (rf_we),
		.waddr  (rf_waddr),
		.wdata  (rf_wdata)
	);

endmodule

`default_nettype wire

//--- rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_core_pkg::*; (
	input  xlen_t      inst,
	input  xlen_t      pc,
	input  logic       in_valid,
	output reg_idx_t   rs1,
	output reg_idx_t   rs2,
	input  xlen_t      rdata1,
	input  xlen_t      rdata2,
	rv_fwd_if.sink     fwd_ex,
	rv_fwd_if.sink     fwd_rs,
	rv_stage_if.decode stage
);

	opcode_t opcode;
	funct3_t funct3;
	logic    funct7_5;
	xlen_t   imm_i;
	xlen_t   imm_b;
	xlen_t   imm_j;
	xlen_t   imm_u;
	logic    rs1_from_ex;
	logic    rs1_from_rs;
	logic    rs2_from_ex;
	logic    rs2_from_rs;
	xlen_t   src1;
	xlen_t   src2;

	// ------------------------------
	// Fields and immediates
	assign opcode   = inst[6:0];
	assign funct3   = inst[14:12];
	assign funct7_5 = inst[30];
	assign rs1      = inst[19:15];
	assign rs2      = inst[24:20];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};

	// ------------------------------
	// Forwarding, execute is the younger source
	assign rs1_from_ex = fwd_ex.valid && fwd_ex.we && (fwd_ex.rd == rs1) && (|rs1);
	assign rs1_from_rs = fwd_rs.valid && fwd_rs.we && (fwd_rs.rd == rs1) && (|rs1);
	assign rs2_from_ex = fwd_ex.valid && fwd_ex.we && (fwd_ex.rd == rs2) && (|rs2);
	assign rs2_from_rs = fwd_rs.valid && fwd_rs.we && (fwd_rs.rd == rs2) && (|rs2);

	assign src1 = rs1_from_ex ? fwd_ex.data : (rs1_from_rs ? fwd_rs.data : rdata1);
	assign src2 = rs2_from_ex ? fwd_ex.data : (rs2_from_rs ? fwd_rs.data : rdata2);

	assign stage.valid = in_valid; // Source holds inst until accepted
	assign stage.pc    = pc;
	assign stage.rd    = inst[11:7];

	// ------------------------------
	// Control decode and operand select
	always_comb begin
		stage.reg_we    = 1'b0;
		stage.alu_op    = ADD;
		stage.op_a      = '0;
		stage.op_b      = '0;
		stage.imm       = '0;
		stage.is_branch = 1'b0;
		stage.is_jump   = 1'b0;
		stage.illegal   = 1'b0;
		case (opcode)
			OPC_OP_IMM: begin
				stage.imm    = imm_i;
				stage.op_a   = src1;
				stage.op_b   = imm_i;
				stage.reg_we = 1'b1;
				stage.alu_op = alu_op_e'({(funct3 == F3_SR) ? funct7_5 : 1'b0, funct3});
			end
			OPC_OP: begin
				stage.op_a   = src1;
				stage.op_b   = src2;
				stage.reg_we = 1'b1;
				stage.alu_op = alu_op_e'({funct7_5, funct3});
			end
			OPC_BRANCH: begin
				stage.imm       = imm_b;
				stage.op_a      = src1;
				stage.op_b      = src2;
				stage.is_branch = 1'b1;
				case (funct3)
					F3_BEQ:  stage.alu_op = EQ;
					F3_BNE:  stage.alu_op = NE;
					F3_BLT:  stage.alu_op = LT;
					F3_BGE:  stage.alu_op = GE;
					F3_BLTU: stage.alu_op = LTU;
					F3_BGEU: stage.alu_op = GEU;
					default: stage.alu_op = ADD; // Reserved funct3, never taken
				endcase
			end
			OPC_LUI: begin
				stage.imm    = imm_u;
				stage.op_b   = imm_u; // Zero plus immediate
				stage.reg_we = 1'b1;
			end
			OPC_AUIPC: begin
				stage.imm    = imm_u;
				stage.op_a   = pc;
				stage.op_b   = imm_u;
				stage.reg_we = 1'b1;
			end
			OPC_JAL: begin
				stage.imm     = imm_j;
				stage.op_a    = pc;
				stage.op_b    = imm_j;
				stage.reg_we  = 1'b1;
				stage.is_jump = 1'b1;
			end
			OPC_JALR: begin
				stage.imm     = imm_i;
				stage.op_a    = src1;
				stage.op_b    = imm_i;
				stage.reg_we  = 1'b1;
				stage.is_jump = 1'b1;
			end
			default: begin
				stage.illegal = 1'b1; // Retires with no write
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_core_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	rv_stage_if.execute stage,
	rv_fwd_if.source    fwd,
	output logic        ex_valid,
	input  logic        ex_ready,
	output xlen_t       ex_pc,
	output reg_idx_t    ex_rd,
	output logic        ex_we,
	output xlen_t       ex_data,
	output logic        ex_taken,
	output xlen_t       ex_target,
	output logic        ex_illegal
);

	logic     valid_q;
	xlen_t    pc_q;
	reg_idx_t rd_q;
	logic     we_q;
	alu_op_e  alu_op_q;
	xlen_t    op_a_q;
	xlen_t    op_b_q;
	xlen_t    imm_q;
	logic     is_branch_q;
	logic     is_jump_q;
	logic     illegal_q;
	logic     cmp_true;
	xlen_t    alu_res;
	xlen_t    pc_plus4;
	xlen_t    jump_sum;

	assign stage.ready = !valid_q || ex_ready; // Empty or handing over

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else if (stage.ready) begin
			valid_q <= stage.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (stage.valid && stage.ready) begin
			pc_q        <= stage.pc;
			rd_q        <= stage.rd;
			we_q        <= stage.reg_we;
			alu_op_q    <= stage.alu_op;
			op_a_q      <= stage.op_a;
			op_b_q      <= stage.op_b;
			imm_q       <= stage.imm;
			is_branch_q <= stage.is_branch;
			is_jump_q   <= stage.is_jump;
			illegal_q   <= stage.illegal;
		end
	end

	// ------------------------------
	// ALU and branch compare
	always_comb begin
		case (alu_op_q)
			EQ:      cmp_true = (op_a_q == op_b_q);
			NE:      cmp_true = (op_a_q != op_b_q);
			LT:      cmp_true = ($signed(op_a_q) < $signed(op_b_q));
			GE:      cmp_true = ($signed(op_a_q) >= $signed(op_b_q));
			LTU:     cmp_true = (op_a_q < op_b_q);
			GEU:     cmp_true = (op_a_q >= op_b_q);
			default: cmp_true = 1'b0;
		endcase
	end

	always_comb begin
		case (alu_op_q)
			ADD:     alu_res = op_a_q + op_b_q;
			SUB:     alu_res = op_a_q - op_b_q;
			SLL:     alu_res = op_a_q << op_b_q[4:0];
			SLT:     alu_res = {31'b0, $signed(op_a_q) < $signed(op_b_q)};
			SLTU:    alu_res = {31'b0, op_a_q < op_b_q};
			XOR:     alu_res = op_a_q ^ op_b_q;
			SRL:     alu_res = op_a_q >> op_b_q[4:0];
			SRA:     alu_res = xlen_t'($signed(op_a_q) >>> op_b_q[4:0]);
			OR:      alu_res = op_a_q | op_b_q;
			AND:     alu_res = op_a_q & op_b_q;
			default: alu_res = {31'b0, cmp_true}; // Compare ops
		endcase
	end

	assign pc_plus4 = pc_q + 32'd4;
	assign jump_sum = op_a_q + imm_q; // op_a is pc for JAL, rs1 for JALR

	assign ex_valid   = valid_q;
	assign ex_pc      = pc_q;
	assign ex_rd      = rd_q;
	assign ex_we      = we_q;
	assign ex_data    = is_jump_q ? pc_plus4 : alu_res; // Link address
	assign ex_taken   = is_jump_q || (is_branch_q && cmp_true);
	assign ex_illegal = illegal_q;

	// Bit 0 cleared for every jump, a JAL target is already even
	assign ex_target = is_jump_q ? {jump_sum[31:1], 1'b0} :
		(is_branch_q ? pc_q + imm_q : pc_plus4);

	assign fwd.valid = valid_q;
	assign fwd.rd    = rd_q;
	assign fwd.we    = we_q;
	assign fwd.data  = ex_data;

	a_ex_hold: assert property (@(posedge clk) disable iff (!arst_n)
		ex_valid && !ex_ready |=> ex_valid && $stable({ex_pc, ex_rd, ex_we, ex_data,
		ex_taken, ex_target, ex_illegal}));

endmodule

`default_nettype wire

//--- rv_pipe_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rv_stage_if import rv_core_pkg::*; ();
	logic     valid;
	logic     ready;
	xlen_t    pc;
	reg_idx_t rd;
	logic     reg_we;
	alu_op_e  alu_op;
	xlen_t    op_a;
	xlen_t    op_b;
	xlen_t    imm;
	logic     is_branch;
	logic     is_jump;
	logic     illegal;

	modport decode (
		output valid, pc, rd, reg_we, alu_op, op_a, op_b, imm, is_branch, is_jump, illegal,
		input  ready
	);

	modport execute (
		input  valid, pc, rd, reg_we, alu_op, op_a, op_b, imm, is_branch, is_jump, illegal,
		output ready
	);
endinterface

// One younger stage offering its result back to decode
interface rv_fwd_if import rv_core_pkg::*; ();
	logic     valid;
	reg_idx_t rd;
	logic     we;
	xlen_t    data;

	modport source (output valid, rd, we, data);
	modport sink (input valid, rd, we, data);
endinterface

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_core_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	output xlen_t    rdata1,
	output xlen_t    rdata2,
	input  logic     we,
	input  reg_idx_t waddr,
	input  xlen_t    wdata
);

	xlen_t regs [NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin // x0 is never written
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

	a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n) regs[0] == '0);

endmodule

`default_nettype wire

//--- rv_result.sv
`timescale 1ns/1ps
`default_nettype none

module rv_result import rv_core_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     ex_valid,
	output logic     ex_ready,
	input  xlen_t    ex_pc,
	input  reg_idx_t ex_rd,
	input  logic     ex_we,
	input  xlen_t    ex_data,
	input  logic     ex_taken,
	input  xlen_t    ex_target,
	input  logic     ex_illegal,
	rv_fwd_if.source fwd,
	output logic     rf_we,
	output reg_idx_t rf_waddr,
	output xlen_t    rf_wdata,
	output logic     retire_valid,
	input  logic     retire_ready,
	output xlen_t    retire_pc,
	output reg_idx_t retire_rd,
	output logic     retire_we,
	output xlen_t    retire_data,
	output logic     retire_taken,
	output xlen_t    retire_target,
	output logic     retire_illegal
);

	logic valid_q;

	assign ex_ready = !valid_q || retire_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else if (ex_ready) begin
			valid_q <= ex_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid && ex_ready) begin
			retire_pc      <= ex_pc;
			retire_rd      <= ex_rd;
			retire_we      <= ex_we;
			retire_data    <= ex_data;
			retire_taken   <= ex_taken;
			retire_target  <= ex_target;
			retire_illegal <= ex_illegal;
		end
	end

	assign retire_valid = valid_q;

	// ------------------------------
	// Register write on the retire handshake
	assign rf_we    = valid_q && retire_ready && retire_we;
	assign rf_waddr = retire_rd;
	assign rf_wdata = retire_data;

	assign fwd.valid = valid_q; // Covers the gap until the write lands
	assign fwd.rd    = retire_rd;
	assign fwd.we    = retire_we;
	assign fwd.data  = retire_data;

	a_retire_hold: assert property (@(posedge clk) disable iff (!arst_n)
		retire_valid && !retire_ready |=> retire_valid && $stable({retire_pc, retire_rd,
		retire_we, retire_data, retire_taken, retire_target, retire_illegal}));

endmodule

`default_nettype wire

//--- src.f
rv_core_pkg.sv
rv_pipe_if.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core_top.sv
tb_rv_core.sv

//--- tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_core_pkg::*; ();

	localparam int CLK_PERIOD     = 20;
	localparam int N_TOTAL        = 31 + 60 + 40 + 40 + 30 + 80; // Instructions over all tests
	localparam int TIMEOUT_CYCLES = N_TOTAL * 40 + 8;

	typedef struct packed {
		xlen_t    pc;
		reg_idx_t rd;
		logic     we;
		xlen_t    data;
		logic     taken;
		logic     ctrl;    // Target is defined
		xlen_t    target;
		logic     illegal;
		int       cyc;     // Accept cycle
	} retire_t;

	logic     clk;
	logic     arst_n;
	logic     in_valid;
	logic     in_ready;
	xlen_t    in_inst;
	xlen_t    in_pc;
	logic     retire_valid;
	logic     retire_ready;
	xlen_t    retire_pc;
	reg_idx_t retire_rd;
	logic     retire_we;
	xlen_t    retire_data;
	logic     retire_taken;
	xlen_t    retire_target;
	logic     retire_illegal;

	integer       seed;
	xlen_t        model_regs [NUM_REGS];
	retire_t      exp_q [$];
	retire_t      acc_r;
	retire_t      expd;
	logic         bp_en;
	logic         hold_pending;
	logic [103:0] held;
	xlen_t        next_pc;
	xlen_t        inst_w;
	int           errors;
	int           retired;
	int           tests_failed;
	int           test_num;
	int           err_start;
	int           ret_start;

	rv_core_top i_rv_core_top (
		.clk            (clk),
		.arst_n         (arst_n),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.in_inst        (in_inst),
		.in_pc          (in_pc),
		.retire_valid   (retire_valid),
		.retire_ready   (retire_ready),
		.retire_pc      (retire_pc),
		.retire_rd      (retire_rd),
		.retire_we      (retire_we),
		.retire_data    (retire_data),
		.retire_taken   (retire_taken),
		.retire_target  (retire_target),
		.retire_illegal (retire_illegal)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------
	// RV32I reference model in program order
	function automatic retire_t rv_model(input xlen_t inst, input xlen_t pc,
			inout xlen_t regs [NUM_REGS]);
		retire_t    r;
		xlen_t      a;
		xlen_t      b;
		xlen_t      imm_i;
		xlen_t      imm_b;
		xlen_t      imm_j;
		xlen_t      imm_u;
		logic [2:0] f3;
		r     = '0;
		f3    = inst[14:12];
		a     = regs[inst[19:15]];
		b     = regs[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		imm_u = {inst[31:12], 12'b0};
		r.pc  = pc;
		r.rd  = inst[11:7];
		case (inst[6:0])
			OPC_OP_IMM, OPC_OP: begin
				r.we = 1'b1;
				if (inst[6:0] == OPC_OP_IMM) b = imm_i;
				case (f3)
					3'b000:  r.data = (inst[6:0] == OPC_OP && inst[30]) ? a - b : a + b;
					3'b001:  r.data = a << b[4:0];
					3'b010:  r.data = {31'b0, $signed(a) < $signed(b)};
					3'b011:  r.data = {31'b0, a < b};
					3'b100:  r.data = a ^ b;
					3'b101:  r.data = inst[30] ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
					3'b110:  r.data = a | b;
					default: r.data = a & b;
				endcase
			end
			OPC_LUI: begin
				r.we     = 1'b1;
				r.data   = imm_u;
				r.ctrl   = 1'b1;
				r.target = pc + 32'd4; // Falls through
			end
			OPC_AUIPC: begin
				r.we     = 1'b1;
				r.data   = pc + imm_u;
				r.ctrl   = 1'b1;
				r.target = pc + 32'd4; // Falls through
			end
			OPC_JAL, OPC_JALR: begin
				r.we     = 1'b1;
				r.data   = pc + 32'd4; // Link address
				r.taken  = 1'b1;
				r.ctrl   = 1'b1;
				r.target = (inst[6:0] == OPC_JAL) ? pc + imm_j : (a + imm_i) & ~32'd1;
			end
			OPC_BRANCH: begin
				r.ctrl   = 1'b1;
				r.target = pc + imm_b;
				case (f3)
					3'b000:  r.taken = (a == b);
					3'b001:  r.taken = (a != b);
					3'b100:  r.taken = ($signed(a) < $signed(b));
					3'b101:  r.taken = ($signed(a) >= $signed(b));
					3'b110:  r.taken = (a < b);
					default: r.taken = (a >= b);
				endcase
			end
			default: r.illegal = 1'b1;
		endcase
		if (r.we && r.rd != 5'd0) regs[r.rd] = r.data;
		return r;
	endfunction

	// ------------------------------
	// Random instruction builders
	function automatic reg_idx_t pick_reg();
		return reg_idx_t'(1 + {$random(seed)} % 7); // x1..x7 keeps dependencies dense
	endfunction

	function automatic xlen_t alu_inst();
		logic [2:0]  f3;
		logic [11:0] imm;
		logic        alt;
		xlen_t       r;
		int          kind;
		kind = {$random(seed)} % 3;
		f3   = $random(seed);
		alt  = $random(seed);
		imm  = $random(seed);
		r    = $random(seed);
		if (kind == 0) begin
			return {(alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
				pick_reg(), pick_reg(), f3, pick_reg(), OPC_OP};
		end
		if (kind == 1) begin
			if (f3 == 3'b001) imm[11:5] = 7'h00;
			if (f3 == 3'b101) imm[11:5] = alt ? 7'h20 : 7'h00; // SRAI or SRLI
			return {imm, pick_reg(), f3, pick_reg(), OPC_OP_IMM};
		end
		return {r[31:12], pick_reg(), OPC_LUI}; // Seeds fresh values
	endfunction

	function automatic xlen_t jump_inst();
		xlen_t r;
		int    kind;
		kind = {$random(seed)} % 4;
		r    = $random(seed);
		case (kind)
			0:       return {r[31:12], pick_reg(), OPC_LUI};
			1:       return {r[31:12], pick_reg(), OPC_AUIPC};
			2:       return {r[31:12], pick_reg(), OPC_JAL};
			default: return {r[31:20], pick_reg(), 3'b000, pick_reg(), OPC_JALR};
		endcase
	endfunction

	function automatic xlen_t branch_inst();
		logic [2:0] f3_set [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		xlen_t      r;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		r   = $random(seed);
		rs1 = pick_reg();
		rs2 = (($random(seed) & 3) == 0) ? rs1 : pick_reg(); // Equal operands now and then
		return {r[31:25], rs2, rs1, f3_set[{$random(seed)} % 6], r[11:7], OPC_BRANCH};
	endfunction

	function automatic xlen_t illegal_inst();
		opcode_t opc_set [4] = '{7'b0000011, 7'b0100011, 7'b0001111, 7'b1110011};
		xlen_t   r;
		r = $random(seed);
		return {r[31:7], opc_set[{$random(seed)} % 4]};
	endfunction

	function automatic xlen_t mixed_inst();
		case ({$random(seed)} % 4)
			0:       return alu_inst();
			1:       return jump_inst();
			2:       return branch_inst();
			default: return illegal_inst();
		endcase
	endfunction

	// ------------------------------
	// Driver tasks start and end on a falling edge
	task automatic mismatch(input string sig, input xlen_t expv, input xlen_t actv);
		errors++;
		$display("ERROR %0t %s: expected %h, actual %h", $time, sig, expv, actv);
	endtask

	task automatic step();
		@(posedge clk);
		@(negedge clk);
		retire_ready = bp_en ? (($random(seed) & 3) != 0) : 1'b1;
	endtask

	task automatic issue(input xlen_t inst);
		logic took;
		in_valid = 1'b1;
		in_inst  = inst;
		in_pc    = next_pc;
		do begin
			@(posedge clk);
			took = in_ready; // Value before the edge
			@(negedge clk);
			retire_ready = bp_en ? (($random(seed) & 3) != 0) : 1'b1;
		end while (!took);
		next_pc = next_pc + 32'd4;
	endtask

	task automatic bubble();
		in_valid = 1'b0;
		step();
	endtask

	task automatic begin_test();
		err_start = errors;
		ret_start = retired;
	endtask

	task automatic end_test(input string name);
		in_valid = 1'b0;
		while (exp_q.size() != 0) step();
		test_num++;
		if (errors != err_start) tests_failed++;
		$display("Test %0d %s: %0d retired, %0d errors", test_num, name,
			retired - ret_start, errors - err_start);
	endtask

	// ------------------------------
	// Accept monitor and compare process
	always @(posedge clk) begin
		if (arst_n && in_valid && in_ready) begin
			acc_r     = rv_model(in_inst, in_pc, model_regs);
			acc_r.cyc = int'($time / CLK_PERIOD);
			exp_q.push_back(acc_r);
		end
	end

	always @(posedge clk) begin
		if (arst_n) begin
			if (hold_pending) begin
				if (!retire_valid) begin
					errors++;
					$display("ERROR %0t retire_valid fell before the instruction was taken",
						$time);
				end else if ({retire_pc, retire_rd, retire_we, retire_data, retire_taken,
						retire_target, retire_illegal} !== held) begin
					errors++;
					$display("ERROR %0t retire payload: expected %h, actual %h", $time, held,
						{retire_pc, retire_rd, retire_we, retire_data, retire_taken,
						retire_target, retire_illegal});
				end
			end
			if (retire_valid && retire_ready) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("ERROR %0t an instruction retired that was never issued", $time);
				end else begin
					expd = exp_q.pop_front();
					retired++;
					if (retire_pc !== expd.pc) mismatch("retire_pc", expd.pc, retire_pc);
					if (retire_we !== expd.we) mismatch("retire_we", expd.we, retire_we);
					if (retire_illegal !== expd.illegal)
						mismatch("retire_illegal", expd.illegal, retire_illegal);
					if (retire_taken !== expd.taken)
						mismatch("retire_taken", expd.taken, retire_taken);
					if (expd.we && retire_rd !== expd.rd)
						mismatch("retire_rd", expd.rd, retire_rd);
					if (expd.we && retire_data !== expd.data)
						mismatch("retire_data", expd.data, retire_data);
					if (expd.ctrl && retire_target !== expd.target)
						mismatch("retire_target", expd.target, retire_target);
					if (!bp_en && int'($time / CLK_PERIOD) - expd.cyc != 2) begin
						errors++;
						$display("ERROR %0t pc %h did not retire two cycles after accept",
							$time, expd.pc);
					end
				end
			end
			hold_pending = retire_valid && !retire_ready;
			held = {retire_pc, retire_rd, retire_we, retire_data, retire_taken, retire_target,
				retire_illegal};
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Run timed out after %0d cycles with %0d instructions still in flight",
			TIMEOUT_CYCLES, exp_q.size());
		$display("Test failures found");
		$finish;
	end

	// ------------------------------
	// Test sequence
	initial begin
		seed         = 60953;
		arst_n       = 1'b0;
		in_valid     = 1'b0;
		in_inst      = '0;
		in_pc        = '0;
		retire_ready = 1'b1;
		bp_en        = 1'b0;
		hold_pending = 1'b0;
		held         = '0;
		next_pc      = 32'h0000_1000;
		inst_w       = '0;
		errors       = 0;
		retired      = 0;
		tests_failed = 0;
		test_num     = 0;
		for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		begin_test();
		if (in_ready !== 1'b1) mismatch("in_ready", 1, in_ready);
		if (retire_valid !== 1'b0) mismatch("retire_valid", 0, retire_valid);
		for (int k = 1; k < NUM_REGS; k++) begin
			// Writes only a register already read
			issue({7'h00, reg_idx_t'(k), 5'd0, 3'b000, reg_idx_t'(k - 1), OPC_OP});
		end
		end_test("reset state");

		begin_test();
		repeat (60) issue(alu_inst());
		end_test("ALU back to back");

		begin_test();
		repeat (40) issue(jump_inst());
		end_test("LUI AUIPC JAL JALR");

		begin_test();
		repeat (20) begin
			issue(branch_inst());
			issue(alu_inst()); // Keeps operand values moving
		end
		end_test("branches");

		begin_test();
		for (int k = 0; k < 30; k++) begin
			inst_w = alu_inst();
			if (k % 3 == 0) inst_w[11:7] = 5'd0;  // Write to x0
			if (k % 3 == 2) inst_w[19:15] = 5'd0; // Read of x0
			issue((k % 3 == 1) ? illegal_inst() : inst_w);
		end
		end_test("x0 and illegal");

		begin_test();
		bp_en = 1'b1;
		repeat (80) begin
			if (($random(seed) & 3) == 0) bubble();
			issue(mixed_inst());
		end
		end_test("retire back-pressure");
		bp_en = 1'b0;

		$display("Summary: %0d tests, %0d failed, %0d retired, %0d errors",
			test_num, tests_failed, retired, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire
